//--- hw/emac_tx_cfg.svh
// eMAC transmit buffer configuration
`ifndef EMAC_TX_CFG_SVH
`define EMAC_TX_CFG_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define EMAC_DATA_W     8       // one byte per beat
`define EMAC_LEN_W      16      // frame length field
`define EMAC_TYPE_W     16      // protocol type field

//////////////////////////////
// storage
//////////////////////////////

// data RAM, wraps on its power-of-two size
`define EMAC_RAM_DEPTH  2048
`define EMAC_RAM_AW     11

// descriptor queue
`define EMAC_DESC_DEPTH 32
`define EMAC_DESC_AW    5

//////////////////////////////
// frame limits and codes
//////////////////////////////

`define EMAC_MAX_FRAME  1500    // largest frame the RAM must still take
`define EMAC_SMD_E      8'hD5   // express start-of-frame delimiter

`endif

//--- hw/emac_types_pkg.sv
// eMAC datapath types
package emac_types_pkg;

`include "emac_tx_cfg.svh"

    // one stream beat
    typedef logic [`EMAC_DATA_W-1:0] byte_t;

    // frame length in bytes
    typedef logic [`EMAC_LEN_W-1:0] len_t;

    // protocol type as passed to the framer
    typedef logic [`EMAC_TYPE_W-1:0] frame_type_t;

    // data RAM address
    typedef logic [`EMAC_RAM_AW-1:0] ram_addr_t;

    // bytes held, one bit wider than the address so a full RAM fits
    typedef logic [`EMAC_RAM_AW:0] fill_t;

    // start mPacket delimiter
    typedef logic [7:0] smd_t;

endpackage

//--- hw/emac_ctrl_pkg.sv
// eMAC control types
package emac_ctrl_pkg;

    // transmit scheduler
    //   IDLE  wait for a descriptor and a free medium
    //   LOAD  pop the descriptor, SMD goes out
    //   SEND  one RAM read per cycle until the frame is done
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        SEND = 2'd2
    } sched_state_e;

endpackage

//--- hw/emac_desc_if.sv
// frame descriptor channel
interface emac_desc_if;

    import emac_types_pkg::*;

    // write side, frame store to FIFO
    logic        push;      // first beat of a frame
    len_t        wr_len;
    frame_type_t wr_type;
    logic        full;

    // read side, FIFO to scheduler
    logic        pop;       // drop head entry
    len_t        rd_len;    // head, valid while !empty
    frame_type_t rd_type;
    logic        empty;

    modport writer (
        output push, wr_len, wr_type,
        input  full
    );

    modport fifo (
        input  push, wr_len, wr_type, pop,
        output full, rd_len, rd_type, empty
    );

    modport reader (
        output pop,
        input  rd_len, rd_type, empty
    );

endinterface

//--- hw/emac_desc_fifo.sv
// descriptor FIFO, first-word fall-through
`include "emac_tx_cfg.svh"

module emac_desc_fifo (
    input  logic        i_clk,
    input  logic        i_rst,
    emac_desc_if.fifo   desc
);

    import emac_types_pkg::*;

    // entry storage, no reset on payload
    len_t        len_mem  [`EMAC_DESC_DEPTH];
    frame_type_t type_mem [`EMAC_DESC_DEPTH];

    logic [`EMAC_DESC_AW-1:0] wr_ptr;
    logic [`EMAC_DESC_AW-1:0] rd_ptr;
    logic [`EMAC_DESC_AW:0]   count;   // 0 .. depth

    logic do_wr;
    logic do_rd;

    assign do_wr = desc.push && !desc.full;
    assign do_rd = desc.pop && !desc.empty;

    // pointers and occupancy
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1; // natural wrap
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            len_mem[wr_ptr]  <= desc.wr_len;
            type_mem[wr_ptr] <= desc.wr_type;
        end
    end

    // head shown straight from the array
    assign desc.rd_len  = len_mem[rd_ptr];
    assign desc.rd_type = type_mem[rd_ptr];

    assign desc.empty = (count == '0);
    assign desc.full  = (count == `EMAC_DESC_DEPTH);

endmodule

//--- hw/emac_frame_store.sv
// frame data store with descriptor push
`include "emac_tx_cfg.svh"

module emac_frame_store (
    input  logic                        i_clk,
    input  logic                        i_rst,
    // input stream
    input  emac_types_pkg::byte_t       i_tx_data,
    input  emac_types_pkg::len_t        i_tx_len,
    input  emac_types_pkg::frame_type_t i_tx_type,
    input  logic                        i_tx_last,
    input  logic                        i_tx_valid,
    output logic                        o_tx_ready,
    // descriptor push
    emac_desc_if.writer                 desc,
    // read port for the scheduler
    input  logic                        i_rd_en,
    output emac_types_pkg::byte_t       o_rd_data,
    output logic                        o_rd_vld
);

    import emac_types_pkg::*;

    // room left must still hold a full-size frame
    localparam int FILL_LIMIT = `EMAC_RAM_DEPTH - `EMAC_MAX_FRAME;

    byte_t     ram [`EMAC_RAM_DEPTH];

    ram_addr_t wr_addr;
    ram_addr_t rd_addr;
    fill_t     fill;
    fill_t     fill_next;
    logic      ready_q;     // fill below limit
    logic      in_frame;    // between first and last beat
    logic      wr_en;
    logic      first_beat;

    //////////////////////////////
    // input side
    //////////////////////////////

    assign o_tx_ready = ready_q && !desc.full;  // descriptor room too
    assign wr_en      = i_tx_valid && o_tx_ready;
    assign first_beat = wr_en && !in_frame;

    // one descriptor per frame, sampled on its first beat
    assign desc.push    = first_beat;
    assign desc.wr_len  = i_tx_len;
    assign desc.wr_type = i_tx_type;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            in_frame <= 1'b0;
        end else if (wr_en) begin
            in_frame <= !i_tx_last; // single-beat frame never sets it
        end
    end

    //////////////////////////////
    // fill tracking
    //////////////////////////////

    always_comb begin
        case ({wr_en, i_rd_en})
            2'b10:   fill_next = fill + 1'b1;
            2'b01:   fill_next = fill - 1'b1;
            default: fill_next = fill;          // write and read cancel
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            fill    <= '0;
            ready_q <= 1'b0;                    // rises one cycle after reset
        end else begin
            fill    <= fill_next;
            ready_q <= (fill_next <= FILL_LIMIT);
        end
    end

    //////////////////////////////
    // RAM and pointers
    //////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_addr  <= '0;
            rd_addr  <= '0;
            o_rd_vld <= 1'b0;
        end else begin
            if (wr_en)   wr_addr <= wr_addr + 1'b1; // power-of-two wrap
            if (i_rd_en) rd_addr <= rd_addr + 1'b1;
            o_rd_vld <= i_rd_en;                    // tracks registered read
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            ram[wr_addr] <= i_tx_data;
        end
        if (i_rd_en) begin
            o_rd_data <= ram[rd_addr];  // data one cycle after strobe
        end
    end

endmodule

//--- hw/emac_tx_sched.sv
// eMAC transmit scheduler
`include "emac_tx_cfg.svh"

module emac_tx_sched (
    input  logic                        i_clk,
    input  logic                        i_rst,
    emac_desc_if.reader                 desc,
    // frame store read port
    output logic                        o_rd_en,
    input  emac_types_pkg::byte_t       i_rd_data,
    input  logic                        i_rd_vld,
    // pMAC arbitration and framer ready
    input  logic                        i_pmac_busy,
    input  logic                        i_pmac_apply,
    input  logic                        i_rx_ready,
    output logic                        o_emac_busy,
    output logic                        o_emac_apply,
    output logic                        o_emac_pending,
    // framer side
    output emac_types_pkg::byte_t       o_send_data,
    output logic                        o_send_valid,
    output logic                        o_send_last,
    output emac_types_pkg::len_t        o_send_len,
    output emac_types_pkg::frame_type_t o_send_type,
    output emac_types_pkg::smd_t        o_smd,
    output logic                        o_smd_vld
);

    import emac_types_pkg::*;
    import emac_ctrl_pkg::*;

    sched_state_e state;
    sched_state_e state_next;

    len_t remain;       // bytes still to read
    logic start;
    logic last_q;       // rides with the final returning byte

    //////////////////////////////
    // arbitration
    //////////////////////////////

    // framer ready only matters here, a started frame never stalls
    assign start = (state == IDLE) && !desc.empty && !i_pmac_busy
                   && !i_pmac_apply && i_rx_ready;

    assign o_emac_busy    = (state != IDLE) || i_rd_vld;    // covers tail byte
    assign o_emac_apply   = !o_emac_busy && !desc.empty && i_pmac_busy;
    assign o_emac_pending = !desc.empty;

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (start) state_next = LOAD;
            LOAD: state_next = SEND;
            SEND: if (remain == len_t'(1)) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign desc.pop = (state == LOAD);  // head was latched on start
    assign o_rd_en  = (state == SEND);  // one byte per cycle

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= IDLE;
            remain    <= '0;
            o_smd_vld <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            state     <= state_next;
            o_smd_vld <= start;         // high during LOAD
            last_q    <= o_rd_en && (remain == len_t'(1));
            if (start) begin
                remain <= desc.rd_len;
            end else if (o_rd_en) begin
                remain <= remain - 1'b1;
            end
        end
    end

    // frame fields, held until the next frame starts
    always_ff @(posedge i_clk) begin
        if (start) begin
            o_send_len  <= desc.rd_len;
            o_send_type <= desc.rd_type;
            o_smd       <= `EMAC_SMD_E;
        end
    end

    //////////////////////////////
    // framer data
    //////////////////////////////

    // first byte two cycles after the SMD pulse
    assign o_send_data  = i_rd_data;
    assign o_send_valid = i_rd_vld;
    assign o_send_last  = last_q;

endmodule

//--- hw/emac_tx_top.sv
// eMAC transmit buffer top
module emac_tx_top (
    input  logic                        i_clk,
    input  logic                        i_rst,
    // input stream
    input  emac_types_pkg::byte_t       i_tx_data,
    input  emac_types_pkg::len_t        i_tx_len,
    input  emac_types_pkg::frame_type_t i_tx_type,
    input  logic                        i_tx_last,
    input  logic                        i_tx_valid,
    output logic                        o_tx_ready,
    // pMAC exchange
    input  logic                        i_pmac_busy,
    input  logic                        i_pmac_apply,
    output logic                        o_emac_busy,
    output logic                        o_emac_apply,
    output logic                        o_emac_pending,
    // framer
    input  logic                        i_rx_ready,
    output emac_types_pkg::byte_t       o_send_data,
    output logic                        o_send_valid,
    output logic                        o_send_last,
    output emac_types_pkg::len_t        o_send_len,
    output emac_types_pkg::frame_type_t o_send_type,
    // SMD
    output emac_types_pkg::smd_t        o_smd,
    output logic                        o_smd_vld
);

    import emac_types_pkg::*;

    logic  rd_en;       // scheduler read strobe
    byte_t rd_data;
    logic  rd_vld;

    emac_desc_if u_desc_if ();

    emac_desc_fifo u_desc_fifo (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .desc           (u_desc_if.fifo)
    );

    emac_frame_store u_frame_store (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_tx_data      (i_tx_data),
        .i_tx_len       (i_tx_len),
        .i_tx_type      (i_tx_type),
        .i_tx_last      (i_tx_last),
        .i_tx_valid     (i_tx_valid),
        .o_tx_ready     (o_tx_ready),
        .desc           (u_desc_if.writer),
        .i_rd_en        (rd_en),
        .o_rd_data      (rd_data),
        .o_rd_vld       (rd_vld)
    );

    emac_tx_sched u_tx_sched (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .desc           (u_desc_if.reader),
        .o_rd_en        (rd_en),
        .i_rd_data      (rd_data),
        .i_rd_vld       (rd_vld),
        .i_pmac_busy    (i_pmac_busy),
        .i_pmac_apply   (i_pmac_apply),
        .i_rx_ready     (i_rx_ready),
        .o_emac_busy    (o_emac_busy),
        .o_emac_apply   (o_emac_apply),
        .o_emac_pending (o_emac_pending),
        .o_send_data    (o_send_data),
        .o_send_valid   (o_send_valid),
        .o_send_last    (o_send_last),
        .o_send_len     (o_send_len),
        .o_send_type    (o_send_type),
        .o_smd          (o_smd),
        .o_smd_vld      (o_smd_vld)
    );

endmodule

//--- verification/emac_tx_tb.sv
// eMAC transmit buffer testbench
module emac_tx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import emac_types_pkg::*;

    localparam int   NUM_FRAMES = 8;
    localparam int   WAIT_LIMIT = 2000;   // cycles for one blocked beat
    localparam int   END_LIMIT  = 6000;   // cycles for the queue to drain
    localparam smd_t SMD_E_CODE = 8'hd5;  // express start delimiter

    // row of length, type, pMAC busy hold and rx_ready low hold
    typedef struct packed {
        len_t        len;
        frame_type_t typ;
        int          busy_hold;
        int          rx_hold;
    } frame_entry_t;

    localparam frame_entry_t FRAMES [NUM_FRAMES] = '{
        '{16'd64,  16'h88f7, 0,   0},       // plain single frame
        '{16'd1,   16'h0800, 0,   0},       // one byte with last on the first beat
        '{16'd45,  16'h86dd, 0,   0},
        '{16'd120, 16'h8100, 300, 0},       // held back by pMAC
        '{16'd300, 16'h0806, 0,   900},     // framer stalls and the RAM fills
        '{16'd300, 16'h88e5, 0,   0},
        '{16'd200, 16'h22f0, 0,   0},
        '{16'd60,  16'h893f, 0,   0}
    };

    logic        i_clk;
    logic        i_rst;
    byte_t       i_tx_data;
    len_t        i_tx_len;
    frame_type_t i_tx_type;
    logic        i_tx_last;
    logic        i_tx_valid;
    logic        o_tx_ready;
    logic        i_pmac_busy;
    logic        i_pmac_apply;
    logic        o_emac_busy;
    logic        o_emac_apply;
    logic        o_emac_pending;
    logic        i_rx_ready;
    byte_t       o_send_data;
    logic        o_send_valid;
    logic        o_send_last;
    len_t        o_send_len;
    frame_type_t o_send_type;
    smd_t        o_smd;
    logic        o_smd_vld;

    integer seed;
    byte_t  exp_q [$];          // bytes in the order they were driven
    int     mismatch_cnt;
    int     fail_cnt;
    int     pushed;             // frames whose first beat was taken
    int     started;            // SMD pulses seen
    int     done_cnt;
    int     cur;                // table row on the wire
    int     byte_idx;
    int     smd_cyc;
    int     cyc;
    int     busy_left;
    int     rx_left;
    int     apply_seen;
    logic   sending;
    logic   ready_dropped;
    logic   timed_out;
    logic   mon_on;

    emac_tx_top i_emac_tx_top (.*);

    always #50 i_clk = ~i_clk;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_type(input string name, input frame_type_t got,
                              input frame_type_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_smd(input string name, input smd_t got, input smd_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_cnt++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    //////////////////////////////
    // driver
    //////////////////////////////

    // advance to the next falling edge and run the hold counters down
    task automatic step();
        @(negedge i_clk);
        if (busy_left > 0) busy_left--;
        if (rx_left > 0) rx_left--;
        i_pmac_busy = (busy_left > 0);
        i_rx_ready  = (rx_left == 0);
    endtask

    // ready is registered so its value at the falling edge decides the next rising one
    task automatic send_beat(input byte_t d, input logic last, input logic first);
        int waited;
        waited     = 0;
        i_tx_data  = d;
        i_tx_last  = last;
        i_tx_valid = 1'b1;
        while (!o_tx_ready && waited < WAIT_LIMIT) begin
            ready_dropped = 1'b1;   // beat held while blocked
            step();
            waited++;
        end
        if (!o_tx_ready) begin
            report_failure("o_tx_ready stayed low too long, beat never accepted");
            timed_out = 1'b1;
        end else begin
            if (first) pushed++;
            step();                 // taken on this rising edge
        end
    endtask

    task automatic drive_frame(input int k);
        byte_t d;
        int    i;
        if (FRAMES[k].busy_hold > busy_left) busy_left = FRAMES[k].busy_hold;
        if (FRAMES[k].rx_hold > rx_left) rx_left = FRAMES[k].rx_hold;
        i_pmac_busy = (busy_left > 0);
        i_rx_ready  = (rx_left == 0);
        i_tx_len    = FRAMES[k].len;   // held for the whole frame
        i_tx_type   = FRAMES[k].typ;
        for (i = 0; i < int'(FRAMES[k].len) && !timed_out; i++) begin
            d = byte_t'($random(seed));
            exp_q.push_back(d);
            send_beat(d, i == int'(FRAMES[k].len) - 1, i == 0);
        end
    endtask

    //////////////////////////////
    // monitor
    //////////////////////////////

    task automatic observe_cycle();
        logic  exp_pending;
        logic  exp_apply;
        byte_t exp_b;
        exp_pending = (pushed != started);  // popped the cycle after SMD
        exp_apply   = !sending && exp_pending && i_pmac_busy;
        if (exp_apply) apply_seen++;
        check_flag("o_emac_pending", o_emac_pending, exp_pending);
        check_flag("o_emac_apply", o_emac_apply, exp_apply);
        if (o_smd_vld) begin
            if (sending) begin
                report_failure("SMD pulse while a frame is still being sent");
            end else if (started >= NUM_FRAMES) begin
                report_failure("SMD pulse with no frame left to send");
            end else begin
                if (i_pmac_busy) report_failure("frame started while pMAC busy");
                if (!i_rx_ready) report_failure("frame started while rx not ready");
                check_smd("o_smd", o_smd, SMD_E_CODE);
                check_len("o_send_len", o_send_len, FRAMES[started].len);
                check_type("o_send_type", o_send_type, FRAMES[started].typ);
                cur      = started;
                started++;
                sending  = 1'b1;
                smd_cyc  = cyc;
                byte_idx = 0;
            end
        end
        // busy from the SMD cycle through the final byte
        check_flag("o_emac_busy", o_emac_busy, sending);
        if (o_send_valid) begin
            if (!sending) begin
                report_failure("valid byte outside of any frame");
            end else begin
                // byte n lands n+2 cycles after the SMD
                if (cyc != smd_cyc + 2 + byte_idx)
                    report_failure($sformatf("byte %0d of frame %0d on wrong cycle",
                                             byte_idx, cur));
                if (exp_q.size() == 0) begin
                    report_failure("more bytes sent than were driven");
                end else begin
                    exp_b = exp_q.pop_front();
                    check_byte("o_send_data", o_send_data, exp_b);
                end
                check_flag("o_send_last", o_send_last,
                           byte_idx == int'(FRAMES[cur].len) - 1);
                check_len("o_send_len", o_send_len, FRAMES[cur].len);
                check_type("o_send_type", o_send_type, FRAMES[cur].typ);
                byte_idx++;
                if (byte_idx == int'(FRAMES[cur].len)) begin
                    sending = 1'b0;
                    done_cnt++;
                end
            end
        end else begin
            if (o_send_last) report_failure("o_send_last high without o_send_valid");
            if (sending && cyc >= smd_cyc + 2 + byte_idx) begin
                report_failure($sformatf("frame %0d stalled before its last byte", cur));
                sending = 1'b0;     // one report per broken frame
            end
        end
        cyc++;
    endtask

    // sample just after the rising edge while inputs are steady
    always begin
        @(posedge i_clk);
        #1;
        if (mon_on) observe_cycle();
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin : main
        int waited;
        int k;
        seed          = 32'h6dc0;
        mismatch_cnt  = 0;
        fail_cnt      = 0;
        pushed        = 0;
        started       = 0;
        done_cnt      = 0;
        cur           = 0;
        byte_idx      = 0;
        smd_cyc       = 0;
        cyc           = 0;
        busy_left     = 0;
        rx_left       = 0;
        apply_seen    = 0;
        sending       = 1'b0;
        ready_dropped = 1'b0;
        timed_out     = 1'b0;
        mon_on        = 1'b0;
        i_clk         = 1'b0;
        i_rst         = 1'b1;
        i_tx_data     = '0;
        i_tx_len      = '0;
        i_tx_type     = '0;
        i_tx_last     = 1'b0;
        i_tx_valid    = 1'b0;
        i_pmac_busy   = 1'b0;
        i_pmac_apply  = 1'b0;   // pMAC never requests here
        i_rx_ready    = 1'b1;
        repeat (5) @(negedge i_clk);
        i_rst = 1'b0;

        // reset values with ready still low
        check_flag("o_send_valid", o_send_valid, 1'b0);
        check_flag("o_smd_vld", o_smd_vld, 1'b0);
        check_flag("o_emac_busy", o_emac_busy, 1'b0);
        check_flag("o_emac_apply", o_emac_apply, 1'b0);
        check_flag("o_emac_pending", o_emac_pending, 1'b0);
        check_flag("o_tx_ready", o_tx_ready, 1'b0);
        mon_on = 1'b1;
        step();
        check_flag("o_tx_ready", o_tx_ready, 1'b1);

        for (k = 0; k < NUM_FRAMES && !timed_out; k++) begin
            drive_frame(k);
        end
        i_tx_valid = 1'b0;
        i_tx_last  = 1'b0;

        waited = 0;
        while (done_cnt < NUM_FRAMES && waited < END_LIMIT && !timed_out) begin
            step();
            waited++;
        end
        if (done_cnt < NUM_FRAMES && !timed_out)
            report_failure($sformatf("only %0d of %0d frames came out", done_cnt, NUM_FRAMES));
        repeat (4) step();  // nothing extra may follow

        if (exp_q.size() != 0) report_failure("driven bytes never came out");
        if (!ready_dropped) report_failure("o_tx_ready never went low while RAM filled");
        if (apply_seen == 0) report_failure("pMAC hold never raised o_emac_apply");

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/emac_types_pkg.sv
hw/emac_ctrl_pkg.sv
hw/emac_desc_if.sv
hw/emac_desc_fifo.sv
hw/emac_frame_store.sv
hw/emac_tx_sched.sv
hw/emac_tx_top.sv
verification/emac_tx_tb.sv

//--- Makefile
# Verilator flow for the eMAC transmit buffer

VERILATOR ?= verilator
TOP       ?= emac_tx_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
